//--- Makefile
# Verilator build and run for the vector overlay compositor

VERILATOR ?= verilator
TOP       ?= tb_vector_overlay
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG) || ! grep -q "STATUS: PASS" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
ovl_types_pkg.sv
ovl_ctrl_pkg.sv
ovl_mem_if.sv
overlay_loader.sv
overlay_store.sv
overlay_compositor.sv
vector_overlay_top.sv
vector_overlay_assert.sv
tb_vector_overlay.sv

//--- overlay_compositor.sv
// ==============================
// Overlay compositor
// Scans the stored overlay in step with the display and mixes it
// with the vector beam colour, output two cycles after the inputs
// ==============================

`timescale 1ns/1ps

module overlay_compositor
	import ovl_types_pkg::*;
	import ovl_ctrl_pkg::*;
#(
	parameter int DEPTH = 48
) (
	input  logic        clk_sys,
	input  logic        rst,
	input  logic        dl_active,
	input  logic        hblank,
	input  logic        vblank,
	input  rgb8_t       vec_color,
	input  logic        opt_alpha,
	input  beam_color_e beam_color,
	input  logic        opt_tint,
	ovl_mem_if.scan     mem,
	output rgb8_t       out_color,
	output logic        out_hblank,
	output logic        out_vblank
);

	localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(DEPTH - 1);

	// Stage 1, waiting for the store read
	rgb8_t       s1_color;
	logic        s1_alpha;
	beam_color_e s1_beam;
	logic        s1_tint;
	logic        s1_dl_active;
	logic        s1_hblank;
	logic        s1_vblank;

	// Stage 2 mix
	ovl_pixel_t ovl;
	rgb8_t      base;
	rgb8_t      mix;
	logic       beam_on;
	logic       ovl_lit;

	// Nibble to 8 bits by repetition
	function automatic logic [7:0] widen(input logic [3:0] n);
		return {n, n};
	endfunction

	// Move about three quarters of the way towards white
	function automatic logic [7:0] tint_up(input logic [7:0] c);
		logic [7:0] gap;
		gap = 8'd255 - c;
		return c + (gap >> 1) + (gap >> 2);
	endfunction

	// Darken the widened nibble by alpha over 15
	function automatic logic [7:0] alpha_scale(input logic [3:0] n, input logic [3:0] a);
		logic [11:0] prod;
		prod = widen(n) * a;
		return 8'(prod / 12'd15);
	endfunction

	// ==============================
	// Scan address
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			mem.rd_addr <= '0;
		end else if (vblank && !s1_vblank) begin
			// New frame starts at the top of the overlay
			mem.rd_addr <= '0;
		end else if (!hblank && !vblank) begin
			mem.rd_addr <= (mem.rd_addr == LAST_ADDR) ? '0 : mem.rd_addr + 1'b1;
		end
	end

	// ==============================
	// Stage 1 delay
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			s1_dl_active <= 1'b0;
			s1_hblank    <= 1'b1;
			s1_vblank    <= 1'b1;
		end else begin
			s1_dl_active <= dl_active;
			s1_hblank    <= hblank;
			s1_vblank    <= vblank;
		end
	end

	// Beam colour and options travel with their pixel
	always_ff @(posedge clk_sys) begin
		s1_color <= vec_color;
		s1_alpha <= opt_alpha;
		s1_beam  <= beam_color;
		s1_tint  <= opt_tint;
	end

	// ==============================
	// Blend
	// ==============================

	always_comb begin
		// Overlay is dark while loading or before any good download
		ovl     = (s1_dl_active || !mem.has_overlay) ? '0 : mem.rd_data;
		beam_on = |{s1_color.red, s1_color.green, s1_color.blue};
		ovl_lit = |{ovl.red, ovl.green, ovl.blue};

		// Beam colour, either the overlay tint or the vector itself
		if (s1_beam == color_overlay && ovl_lit) begin
			base.red   = widen(ovl.red);
			base.green = widen(ovl.green);
			base.blue  = widen(ovl.blue);
		end else begin
			base = s1_color;
		end

		if (beam_on) begin
			// Bright beam pixels bleed towards white
			if (s1_tint && s1_color.red > TINT_THRESHOLD) begin
				mix.red   = tint_up(base.red);
				mix.green = tint_up(base.green);
				mix.blue  = tint_up(base.blue);
			end else begin
				mix = base;
			end
		end else if (s1_alpha) begin
			// Background only, seen through the overlay alpha
			mix.red   = alpha_scale(ovl.red, ovl.alpha);
			mix.green = alpha_scale(ovl.green, ovl.alpha);
			mix.blue  = alpha_scale(ovl.blue, ovl.alpha);
		end else begin
			mix.red   = widen(ovl.red);
			mix.green = widen(ovl.green);
			mix.blue  = widen(ovl.blue);
		end
	end

	// Output register, second pipeline stage
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			out_color  <= '0;
			out_hblank <= 1'b1;
			out_vblank <= 1'b1;
		end else begin
			out_color  <= mix;
			out_hblank <= s1_hblank;
			out_vblank <= s1_vblank;
		end
	end

endmodule

//--- overlay_loader.sv
// ==============================
// Overlay download loader
// Pairs host bytes into pixels and writes them rotated by 90 degrees
// Address of file pixel (row, col) is (OV_WIDTH-1-col)*OV_HEIGHT + row
// ==============================

`timescale 1ns/1ps

module overlay_loader
	import ovl_types_pkg::*;
	import ovl_ctrl_pkg::*;
#(
	parameter int OV_WIDTH  = 8,
	parameter int OV_HEIGHT = 6
) (
	input  logic       clk_sys,
	input  logic       rst,
	input  logic       dl_active,
	input  logic       dl_wr,
	input  logic [7:0] dl_byte,
	ovl_mem_if.loader  mem
);

	localparam int DEPTH  = OV_WIDTH * OV_HEIGHT;
	localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int ROW_W  = (OV_HEIGHT > 1) ? $clog2(OV_HEIGHT) : 1;
	localparam int COL_W  = (OV_WIDTH > 1) ? $clog2(OV_WIDTH) : 1;

	// First file column lands in the last stored column
	localparam logic [ADDR_W-1:0] FIRST_ADDR = ADDR_W'((OV_WIDTH - 1) * OV_HEIGHT);
	// One file column to the right is one stored column down
	localparam logic [ADDR_W-1:0] COL_STEP   = ADDR_W'(OV_HEIGHT);
	localparam logic [ROW_W-1:0]  LAST_ROW   = ROW_W'(OV_HEIGHT - 1);
	localparam logic [COL_W-1:0]  LAST_COL   = COL_W'(OV_WIDTH - 1);

	load_state_e       state;
	logic [7:0]        low_q;
	logic              dl_active_q;
	logic              got_pixel;
	logic              full;
	logic [ROW_W-1:0]  row;
	logic [COL_W-1:0]  cols_left;
	logic [ADDR_W-1:0] pix_addr;
	ovl_pixel_t        pixel_d;
	logic              take_pixel;

	// Second byte carries alpha and blue, first byte green and red
	assign pixel_d = '{
		alpha: dl_byte[7:4],
		blue:  dl_byte[3:0],
		green: low_q[7:4],
		red:   low_q[3:0]
	};

	// A complete pixel that still fits in the picture
	assign take_pixel = dl_active && dl_wr && (state == load_high_byte) && !full;

	// ==============================
	// FSM and address stepping
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			state         <= load_idle;
			dl_active_q   <= 1'b0;
			got_pixel     <= 1'b0;
			full          <= 1'b0;
			row           <= '0;
			cols_left     <= LAST_COL;
			pix_addr      <= FIRST_ADDR;
			mem.wr_en     <= 1'b0;
			mem.load_done <= 1'b0;
		end else begin
			dl_active_q <= dl_active;
			mem.wr_en   <= take_pixel;
			// Falling dl_active ends the download, but only a real picture counts
			mem.load_done <= dl_active_q && !dl_active && got_pixel;

			if (!dl_active) begin
				// Rearm for the next download
				state     <= load_idle;
				got_pixel <= 1'b0;
				full      <= 1'b0;
				row       <= '0;
				cols_left <= LAST_COL;
				pix_addr  <= FIRST_ADDR;
			end else begin
				case (state)
					load_high_byte: begin
						if (dl_wr) begin
							state <= load_low_byte;
						end
					end
					default: begin
						state <= dl_wr ? load_high_byte : load_low_byte;
					end
				endcase

				if (take_pixel) begin
					got_pixel <= 1'b1;
					if (cols_left == '0) begin
						// End of a file row, restart at the last stored column
						cols_left <= LAST_COL;
						row       <= row + 1'b1;
						pix_addr  <= FIRST_ADDR + ADDR_W'(row) + ADDR_W'(1);
						if (row == LAST_ROW) begin
							// Picture complete, the rest of the stream is dropped
							full <= 1'b1;
						end
					end else begin
						cols_left <= cols_left - 1'b1;
						pix_addr  <= pix_addr - COL_STEP;
					end
				end
			end
		end
	end

	// ==============================
	// Byte and pixel capture
	// ==============================

	always_ff @(posedge clk_sys) begin
		// Hold the first byte of a pair
		if (dl_wr && state != load_high_byte) begin
			low_q <= dl_byte;
		end
		if (take_pixel) begin
			mem.wr_addr <= pix_addr;
			mem.wr_data <= pixel_d;
		end
	end

endmodule

//--- overlay_store.sv
// ==============================
// On-chip overlay buffer
// Registered read, single write port, plus the overlay-valid flag
// ==============================

`timescale 1ns/1ps

module overlay_store
	import ovl_types_pkg::*;
#(
	parameter int DEPTH = 48
) (
	input  logic      clk_sys,
	input  logic      rst,
	input  logic      dl_active,
	ovl_mem_if.store  mem
);

	// Rotated overlay picture
	ovl_pixel_t mem_q [DEPTH];

	logic dl_active_q;

	// Write from the loader, read for the compositor
	always_ff @(posedge clk_sys) begin
		if (mem.wr_en) begin
			mem_q[mem.wr_addr] <= mem.wr_data;
		end
		mem.rd_data <= mem_q[mem.rd_addr];
	end

	// ==============================
	// Overlay valid flag
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			dl_active_q     <= 1'b0;
			mem.has_overlay <= 1'b0;
		end else begin
			dl_active_q <= dl_active;
			// A new download invalidates the old picture at once
			if (dl_active && !dl_active_q) begin
				mem.has_overlay <= 1'b0;
			end else if (mem.load_done) begin
				mem.has_overlay <= 1'b1;
			end
		end
	end

endmodule

//--- ovl_ctrl_pkg.sv
// ==============================
// Control enums for the overlay loader and compositor
// Loader FSM states and the beam colour source option
// ==============================

package ovl_ctrl_pkg;

	// Loader FSM
	// Idle while no download runs
	// low_byte waits for green/red, high_byte waits for alpha/blue
	typedef enum logic [1:0] {
		load_idle      = 2'd0,
		load_low_byte  = 2'd1,
		load_high_byte = 2'd2
	} load_state_e;

	// Where the beam takes its colour from when it hits the overlay
	typedef enum logic {
		color_overlay = 1'b0,
		color_white   = 1'b1
	} beam_color_e;

endpackage

//--- ovl_mem_if.sv
// ==============================
// Overlay memory bundle between loader, store and compositor
// Write side from the loader, read side from the compositor
// ==============================

`timescale 1ns/1ps

interface ovl_mem_if
	import ovl_types_pkg::*;
#(
	parameter int ADDR_W = 6
) ();

	// Write port, one pixel per cycle with wr_en high
	logic              wr_en;
	logic [ADDR_W-1:0] wr_addr;
	ovl_pixel_t        wr_data;
	// Single-cycle pulse at the end of a good download
	logic              load_done;

	// Read port, data one cycle after the address
	logic [ADDR_W-1:0] rd_addr;
	ovl_pixel_t        rd_data;
	// Overlay contents usable
	logic              has_overlay;

	modport loader (
		output wr_en, wr_addr, wr_data, load_done
	);

	modport scan (
		output rd_addr,
		input  rd_data, has_overlay
	);

	modport store (
		input  wr_en, wr_addr, wr_data, load_done, rd_addr,
		output rd_data, has_overlay
	);

endinterface

//--- ovl_types_pkg.sv
// ==============================
// Pixel and colour types for the overlay datapath
// Shared by loader, store, compositor and the testbench model
// ==============================

package ovl_types_pkg;

	// ==============================
	// Overlay pixel
	// ==============================

	// One stored overlay pixel, 4 bits per channel
	// Field order follows the download file, alpha in the top nibble
	typedef struct packed {
		logic [3:0] alpha;
		logic [3:0] blue;
		logic [3:0] green;
		logic [3:0] red;
	} ovl_pixel_t;

	// ==============================
	// Beam and output colour
	// ==============================

	// Full 8-bit colour as used by the vector beam and the video output
	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb8_t;

	// Beam red level above which the beam gets tinted towards white
	// Compared with a strict greater-than
	localparam logic [7:0] TINT_THRESHOLD = 8'd108;

endpackage

//--- tb_vector_overlay.sv
// ==============================
// Testbench for the vector overlay compositor
// Random downloads and beam colours from a fixed seed, checked
// against a reference model two cycles behind the inputs
// ==============================

`timescale 1ns/1ps

module tb_vector_overlay
	import ovl_types_pkg::*;
();

	localparam int OV_WIDTH   = 8;
	localparam int OV_HEIGHT  = 6;
	localparam int DEPTH      = OV_WIDTH * OV_HEIGHT;
	// Raster, 56 active pixels per frame so the address also wraps
	localparam int H_ACTIVE   = 8;
	localparam int H_TOTAL    = 10;
	localparam int V_ACTIVE   = 7;
	localparam int V_TOTAL    = 9;
	localparam int FRAME      = H_TOTAL * V_TOTAL;
	localparam int SYNC_LIMIT = 4 * FRAME;

	logic       clk_sys = 1'b0;
	logic       rst;
	logic       dl_active;
	logic       dl_wr;
	logic [7:0] dl_byte;
	logic       hblank;
	logic       vblank;
	logic [7:0] vec_r;
	logic [7:0] vec_g;
	logic [7:0] vec_b;
	logic       opt_alpha;
	logic       opt_color_white;
	logic       opt_tint;
	logic [7:0] out_r;
	logic [7:0] out_g;
	logic [7:0] out_b;
	logic       out_hblank;
	logic       out_vblank;

	// Reference model state
	ovl_pixel_t model_mem [DEPTH];
	logic       model_has;
	int         scan_addr;
	logic       prev_vblank;
	int         hcnt;
	int         vcnt;
	logic       beam_random;
	logic       cur_alpha;
	logic       cur_white;
	logic       cur_tint;

	// Expected outputs of the two pixels in flight
	rgb8_t hist_color [2];
	logic  hist_hb [2];
	logic  hist_vb [2];
	logic  hist_chk [2];

	string test_name;
	int    test_checks;
	int    test_errors;
	int    total_checks;
	int    total_errors;
	int    test_count;

	always #50 clk_sys = ~clk_sys;

	vector_overlay_top #(
		.OV_WIDTH  (OV_WIDTH),
		.OV_HEIGHT (OV_HEIGHT)
	) vector_overlay_top_i (
		.clk_sys         (clk_sys),
		.rst             (rst),
		.dl_active       (dl_active),
		.dl_wr           (dl_wr),
		.dl_byte         (dl_byte),
		.hblank          (hblank),
		.vblank          (vblank),
		.vec_r           (vec_r),
		.vec_g           (vec_g),
		.vec_b           (vec_b),
		.opt_alpha       (opt_alpha),
		.opt_color_white (opt_color_white),
		.opt_tint        (opt_tint),
		.out_r           (out_r),
		.out_g           (out_g),
		.out_b           (out_b),
		.out_hblank      (out_hblank),
		.out_vblank      (out_vblank)
	);

	// ==============================
	// Reference model
	// ==============================

	// Beam colour, sometimes off and sometimes right at the tint threshold
	function automatic rgb8_t random_beam();
		rgb8_t c;
		c.red   = 8'($urandom);
		c.green = 8'($urandom);
		c.blue  = 8'($urandom);
		case ($urandom % 8)
			0: c = '0;
			1: c.red = 8'(107 + $urandom % 3);
			default: ;
		endcase
		return c;
	endfunction

	// Blend rules, nibble widened as n * 17
	function automatic rgb8_t blend(input rgb8_t v, input ovl_pixel_t p, input logic a,
			input logic white, input logic tint);
		int    nib [3];
		int    vc [3];
		int    ch [3];
		rgb8_t r;
		nib[0] = p.red;
		nib[1] = p.green;
		nib[2] = p.blue;
		vc[0]  = v.red;
		vc[1]  = v.green;
		vc[2]  = v.blue;
		for (int i = 0; i < 3; i++) begin
			if (v != '0) begin
				ch[i] = (!white && (nib[0] + nib[1] + nib[2]) != 0) ? nib[i] * 17 : vc[i];
				if (tint && vc[0] > TINT_THRESHOLD) begin
					ch[i] = ch[i] + (255 - ch[i]) / 2 + (255 - ch[i]) / 4;
				end
			end else if (a) begin
				ch[i] = nib[i] * 17 * int'(p.alpha) / 15;
			end else begin
				ch[i] = nib[i] * 17;
			end
		end
		r.red   = 8'(ch[0]);
		r.green = 8'(ch[1]);
		r.blue  = 8'(ch[2]);
		return r;
	endfunction

	task automatic check_output(input rgb8_t want, input logic hb, input logic vb);
		test_checks++;
		assert (out_r == want.red && out_g == want.green && out_b == want.blue &&
				out_hblank == hb && out_vblank == vb)
		else begin
			test_errors++;
			$display("mismatch %s: expected %h_%h_%h hb=%b vb=%b, actual %h_%h_%h hb=%b vb=%b",
				test_name, want.red, want.green, want.blue, hb, vb,
				out_r, out_g, out_b, out_hblank, out_vblank);
		end
	endtask

	// ==============================
	// One clock of stimulus and checking
	// ==============================

	task automatic tick(input logic act, input logic wr, input logic [7:0] b, input logic chk);
		logic       hb;
		logic       vb;
		rgb8_t      vec;
		ovl_pixel_t ovl;
		rgb8_t      old_color;
		logic       old_hb;
		logic       old_vb;
		logic       old_chk;
		@(posedge clk_sys);
		hb  = (hcnt >= H_ACTIVE);
		vb  = (vcnt >= V_ACTIVE);
		vec = beam_random ? random_beam() : '0;
		dl_active       <= act;
		dl_wr           <= wr;
		dl_byte         <= b;
		hblank          <= hb;
		vblank          <= vb;
		vec_r           <= vec.red;
		vec_g           <= vec.green;
		vec_b           <= vec.blue;
		opt_alpha       <= cur_alpha;
		opt_color_white <= cur_white;
		opt_tint        <= cur_tint;
		// Overlay seen by this pixel, dark while loading
		ovl = (model_has && !act) ? model_mem[scan_addr] : '0;
		// Step the model scan address
		if (vb && !prev_vblank) begin
			scan_addr = 0;
		end else if (!hb && !vb) begin
			scan_addr = (scan_addr + 1) % DEPTH;
		end
		prev_vblank = vb;
		hcnt++;
		if (hcnt == H_TOTAL) begin
			hcnt = 0;
			vcnt = (vcnt + 1) % V_TOTAL;
		end
		// Oldest entry comes out now, newest goes in
		old_color     = hist_color[1];
		old_hb        = hist_hb[1];
		old_vb        = hist_vb[1];
		old_chk       = hist_chk[1];
		hist_color[1] = hist_color[0];
		hist_hb[1]    = hist_hb[0];
		hist_vb[1]    = hist_vb[0];
		hist_chk[1]   = hist_chk[0];
		hist_color[0] = blend(vec, ovl, cur_alpha, cur_white, cur_tint);
		hist_hb[0]    = hb;
		hist_vb[0]    = vb;
		hist_chk[0]   = chk;
		@(negedge clk_sys);
		if (old_chk) begin
			check_output(old_color, old_hb, old_vb);
		end
	endtask

	task automatic run_frame();
		for (int i = 0; i < FRAME; i++) begin
			tick(1'b0, 1'b0, 8'h00, 1'b1);
		end
	endtask

	// Host download of n_bytes random bytes with random gaps
	task automatic download(input int n_bytes);
		int         n;
		logic [7:0] b;
		logic [7:0] low;
		low       = '0;
		model_has = 1'b0;
		tick(1'b1, 1'b0, 8'h00, 1'b1);
		for (int i = 0; i < n_bytes; i++) begin
			if ($urandom % 4 == 0) begin
				tick(1'b1, 1'b0, 8'h00, 1'b1);
			end
			b = 8'($urandom);
			tick(1'b1, 1'b1, b, 1'b1);
			if (i % 2 == 0) begin
				low = b;
			end else begin
				n = i / 2;
				// Rotated store address
				if (n < DEPTH) begin
					model_mem[(OV_WIDTH - 1 - n % OV_WIDTH) * OV_HEIGHT + n / OV_WIDTH] =
						'{alpha: b[7:4], blue: b[3:0], green: low[7:4], red: low[3:0]};
				end
			end
		end
		// First pixel after the fall still sees the flag clear
		tick(1'b0, 1'b0, 8'h00, 1'b1);
		model_has = (n_bytes >= 2);
	endtask

	// Run until the output vblank rises
	task automatic wait_frame_start();
		int   waited;
		logic last;
		logic seen;
		waited = 0;
		seen   = 1'b0;
		last   = out_vblank;
		while (!seen && waited < SYNC_LIMIT) begin
			tick(1'b0, 1'b0, 8'h00, 1'b1);
			seen   = out_vblank && !last;
			last   = out_vblank;
			waited++;
		end
		if (!seen) begin
			test_errors++;
			$display("timeout in %s: no vertical blank at the output within %0d cycles",
				test_name, SYNC_LIMIT);
		end
	endtask

	task automatic start_test(input string name);
		test_name   = name;
		test_checks = 0;
		test_errors = 0;
	endtask

	task automatic end_test();
		test_count++;
		total_checks += test_checks;
		total_errors += test_errors;
		$display("test %s: %0d checks, %0d errors", test_name, test_checks, test_errors);
	endtask

	// ==============================
	// Test sequence
	// ==============================

	initial begin
		void'($urandom(41));
		rst             = 1'b1;
		dl_active       = 1'b0;
		dl_wr           = 1'b0;
		dl_byte         = '0;
		hblank          = 1'b1;
		vblank          = 1'b1;
		vec_r           = '0;
		vec_g           = '0;
		vec_b           = '0;
		opt_alpha       = 1'b0;
		opt_color_white = 1'b0;
		opt_tint        = 1'b0;
		model_has       = 1'b0;
		scan_addr       = 0;
		prev_vblank     = 1'b1;
		hcnt            = 0;
		vcnt            = 0;
		beam_random     = 1'b0;
		cur_alpha       = 1'b0;
		cur_white       = 1'b0;
		cur_tint        = 1'b0;
		hist_chk[0]     = 1'b0;
		hist_chk[1]     = 1'b0;
		test_count      = 0;
		total_checks    = 0;
		total_errors    = 0;
		repeat (3) @(posedge clk_sys);
		rst <= 1'b0;

		start_test("after_reset");
		run_frame();
		beam_random = 1'b1;
		run_frame();
		end_test();

		start_test("load_plain");
		beam_random = 1'b0;
		download(2 * DEPTH);
		wait_frame_start();
		run_frame();
		end_test();

		start_test("load_alpha");
		cur_alpha = 1'b1;
		wait_frame_start();
		run_frame();
		end_test();

		// All colour source and tint combinations
		start_test("beam_mix");
		cur_alpha   = 1'b0;
		beam_random = 1'b1;
		for (int combo = 0; combo < 4; combo++) begin
			cur_white = combo[0];
			cur_tint  = combo[1];
			run_frame();
		end
		end_test();

		// Extra pixels and an odd tail byte
		start_test("reload");
		cur_white = 1'b0;
		cur_tint  = 1'b0;
		download(2 * DEPTH + 10 + 1);
		beam_random = 1'b0;
		wait_frame_start();
		run_frame();
		end_test();

		$display("tests %0d, checks %0d, errors %0d", test_count, total_checks, total_errors);
		if (total_errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

//--- vector_overlay_assert.sv
// ==============================
// Protocol checks on the overlay memory bundle
// Bound into the top level, where loader and store signals meet
// ==============================

`timescale 1ns/1ps

module vector_overlay_assert
	import ovl_ctrl_pkg::*;
(
	input logic        clk_sys,
	input logic        rst,
	input logic        dl_active,
	input logic        byte_wr,
	input load_state_e state,
	input logic        wr_en,
	input logic        load_done,
	input logic        has_overlay
);

	// A pixel write follows the second byte of a pair
	wr_after_high_byte: assert property (@(posedge clk_sys) disable iff (rst)
		$rose(wr_en) |-> $past(byte_wr && state == load_high_byte))
	else $error("wr_en rose without a high byte strobe");

	// End of download is a single pulse
	load_done_pulse: assert property (@(posedge clk_sys) disable iff (rst)
		load_done |=> !load_done)
	else $error("load_done longer than one cycle");

	// New download drops the old picture at once
	overlay_cleared: assert property (@(posedge clk_sys) disable iff (rst)
		$rose(dl_active) |=> !has_overlay)
	else $error("has_overlay still set after a download started");

endmodule

// Loader FSM state from inside the loader, the rest from the shared bundle
bind vector_overlay_top vector_overlay_assert overlay_checks_i (
	.clk_sys     (clk_sys),
	.rst         (rst),
	.dl_active   (dl_active),
	.byte_wr     (dl_wr),
	.state       (overlay_loader_i.state),
	.wr_en       (mem_bus.wr_en),
	.load_done   (mem_bus.load_done),
	.has_overlay (mem_bus.has_overlay)
);

//--- vector_overlay_top.sv
// ==============================
// Vector overlay compositor top level
// Download port in, beam colour in, composed video out
// ==============================

`timescale 1ns/1ps

module vector_overlay_top
	import ovl_types_pkg::*;
	import ovl_ctrl_pkg::*;
#(
	parameter int OV_WIDTH  = 8,
	parameter int OV_HEIGHT = 6
) (
	input  logic       clk_sys,
	input  logic       rst,
	input  logic       dl_active,
	input  logic       dl_wr,
	input  logic [7:0] dl_byte,
	input  logic       hblank,
	input  logic       vblank,
	input  logic [7:0] vec_r,
	input  logic [7:0] vec_g,
	input  logic [7:0] vec_b,
	input  logic       opt_alpha,
	input  logic       opt_color_white,
	input  logic       opt_tint,
	output logic [7:0] out_r,
	output logic [7:0] out_g,
	output logic [7:0] out_b,
	output logic       out_hblank,
	output logic       out_vblank
);

	localparam int DEPTH  = OV_WIDTH * OV_HEIGHT;
	localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	rgb8_t       vec_color;
	rgb8_t       out_color;
	beam_color_e beam_color;

	// Plain ports to typed signals
	assign vec_color  = '{red: vec_r, green: vec_g, blue: vec_b};
	assign beam_color = opt_color_white ? color_white : color_overlay;
	assign out_r      = out_color.red;
	assign out_g      = out_color.green;
	assign out_b      = out_color.blue;

	ovl_mem_if #(.ADDR_W(ADDR_W)) mem_bus ();

	overlay_loader #(
		.OV_WIDTH  (OV_WIDTH),
		.OV_HEIGHT (OV_HEIGHT)
	) overlay_loader_i (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.dl_active (dl_active),
		.dl_wr     (dl_wr),
		.dl_byte   (dl_byte),
		.mem       (mem_bus.loader)
	);

	overlay_store #(
		.DEPTH (DEPTH)
	) overlay_store_i (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.dl_active (dl_active),
		.mem       (mem_bus.store)
	);

	overlay_compositor #(
		.DEPTH (DEPTH)
	) overlay_compositor_i (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.dl_active  (dl_active),
		.hblank     (hblank),
		.vblank     (vblank),
		.vec_color  (vec_color),
		.opt_alpha  (opt_alpha),
		.beam_color (beam_color),
		.opt_tint   (opt_tint),
		.mem        (mem_bus.scan),
		.out_color  (out_color),
		.out_hblank (out_hblank),
		.out_vblank (out_vblank)
	);

endmodule
